/* all.f */
verilog/mdll_pkg.sv
verilog/mdll_ctrl.sv
verilog/mdll_lf.sv
verilog/mdll_fcal_counter.sv
verilog/mdll_dco_decoder.sv
verilog/mdll_core.sv
sim/tb_mdll_core.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, decide on the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -j 0 --top-module tb_mdll_core -f all.f > build.log 2>&1 \
	&& ./obj_dir/Vtb_mdll_core > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -qx "NO ERRORS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* sim/tb_mdll_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mdll_core;

	localparam int DEPTH  = 2;	// sync stages in the DUT
	localparam int T_REF  = 100;	// ref period in ns
	localparam int FB_DIV = 7;	// clk_fb period in ref cycles
	localparam int N_DAC  = 2 ** mdll_pkg::N_DAC_TI;

	logic clk_refp;
	logic rst_n;
	logic bb_out_inc;
	logic inj_mode;
	logic clk_fb;
	logic en_osc;
	logic en_monitor;
	logic load_offset;
	logic [mdll_pkg::N_DCO_O-1:0] dco_ctl_offset;
	mdll_pkg::lf_cfg_t lf_cfg;
	mdll_pkg::fcal_cfg_t fcal_cfg;
	mdll_pkg::dco_ctl_t dco_ctl;
	logic inj_mode_sync;
	logic [mdll_pkg::N_FCAL_CNT-1:0] fcal_cnt;
	logic fcal_ready;
	logic [mdll_pkg::N_DCO_TI-1:0] dco_ctl_fine_mon;
	logic [mdll_pkg::N_DAC_TI-1:0] dac_ctl_mon;

	// check enables raised by the stimulus for a window
	logic chk_reset;
	logic chk_range;
	logic chk_const;
	logic chk_dec;
	logic chk_dac;
	logic chk_ofs;
	logic chk_inj;
	logic chk_fcal;
	int exp_lo;	// inclusive bounds for range checks
	int exp_hi;
	int exp_msb;
	int exp_ofs;
	logic exp_inj;
	logic [mdll_pkg::N_DAC_TI-1:0] exp_dac;
	logic [mdll_pkg::N_DCO_TI-1:0] fine_ref;	// value that must not move
	logic [N_DAC-1:0] sel_b_prev;	// lines up with dac_ctl_mon

	int err_cnt;
	int err_start;
	int test_cnt;
	int fail_cnt;
	integer seed;

	mdll_core #(
		.DEPTH(DEPTH)
	) DUT (
		.clk_refp(clk_refp),
		.rst_n(rst_n),
		.bb_out_inc(bb_out_inc),
		.inj_mode(inj_mode),
		.clk_fb(clk_fb),
		.en_osc(en_osc),
		.en_monitor(en_monitor),
		.load_offset(load_offset),
		.dco_ctl_offset(dco_ctl_offset),
		.lf_cfg(lf_cfg),
		.fcal_cfg(fcal_cfg),
		.dco_ctl(dco_ctl),
		.inj_mode_sync(inj_mode_sync),
		.fcal_cnt(fcal_cnt),
		.fcal_ready(fcal_ready),
		.dco_ctl_fine_mon(dco_ctl_fine_mon),
		.dac_ctl_mon(dac_ctl_mon)
	);

	// ------------------------------
	// clocks
	// ------------------------------
	initial begin
		clk_refp = 1'b0;
		forever #(T_REF/2) clk_refp = ~clk_refp;
	end

	// free running feedback clock off the ref grid
	initial begin
		clk_fb = 1'b0;
		#13;
		forever #(FB_DIV*T_REF/2) clk_fb = ~clk_fb;
	end

	always @(negedge clk_refp) begin
		sel_b_prev <= dco_ctl.dac_sel_b;	// mon is one cycle behind the decoder
	end

	// ------------------------------
	// helpers
	// ------------------------------
	function automatic void log_error(input string msg);
		err_cnt++;
		$display("[ERROR] t=%0d ns: %s", $time, msg);
	endfunction

	function automatic void note_timeout(input string what);
		err_cnt++;
		$display("timeout at %0d ns: %s", $time, what);
	endfunction

	// all ones except a zero at idx
	function automatic logic [N_DAC-1:0] one_cold(input logic [mdll_pkg::N_DAC_TI-1:0] idx);
		logic [N_DAC-1:0] v;
		v = '1;
		v[idx] = 1'b0;
		return v;
	endfunction

	// n ref edges then on to the drive point
	task automatic tick(input int n);
		repeat (n) @(posedge clk_refp);
		#1;
	endtask

	task automatic start_test();
		err_start = err_cnt;
		test_cnt++;
	endtask

	task automatic finish_test(input string name);
		if (err_cnt == err_start) begin
			$display("test %0d %s: ok", test_cnt, name);
		end else begin
			fail_cnt++;
			$display("test %0d %s: failed, %0d errors", test_cnt, name, err_cnt - err_start);
		end
	endtask

	task automatic wait_ready(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (fcal_ready !== level && n < limit) begin
			@(negedge clk_refp);
			n++;
		end
		if (fcal_ready !== level) begin
			note_timeout(what);
		end
		tick(1);
	endtask

	// ------------------------------
	// assertions sampled mid-cycle
	// ------------------------------
	a_reset_zero: assert property (@(negedge clk_refp) !chk_reset ||
		(!fcal_ready && dco_ctl_fine_mon == '0 && dac_ctl_mon == '0 && dco_ctl.offset_thm == '0))
		else log_error("ready, monitors or offset not zero after reset");
	a_reset_mid: assert property (@(negedge clk_refp) !chk_reset ||
		($countones(dco_ctl.fine_msb_thm) == exp_msb && dco_ctl.dac_sel_b == one_cold(exp_dac)))
		else log_error("decoded words not at mid-scale after reset");
	a_single_zero: assert property (@(negedge clk_refp) $countones(dco_ctl.dac_sel_b) == N_DAC - 1)
		else log_error($sformatf("dac_sel_b %h not one-cold", dco_ctl.dac_sel_b));
	a_range: assert property (@(negedge clk_refp) !chk_range ||
		(int'(dco_ctl_fine_mon) >= exp_lo && int'(dco_ctl_fine_mon) <= exp_hi))
		else log_error($sformatf("fine word %0d, expected %0d..%0d",
			dco_ctl_fine_mon, exp_lo, exp_hi));
	a_const: assert property (@(negedge clk_refp) !chk_const || dco_ctl_fine_mon == fine_ref)
		else log_error($sformatf("fine word moved to %0d, held %0d", dco_ctl_fine_mon, fine_ref));
	a_dec: assert property (@(negedge clk_refp) !chk_dec ||
		($countones(dco_ctl.fine_msb_thm) == int'(dco_ctl_fine_mon >> mdll_pkg::N_PI) &&
		 $countones(dco_ctl.fine_lsb_thm) == int'(dco_ctl_fine_mon[mdll_pkg::N_PI-1:0])))
		else log_error($sformatf("thermometer codes do not match fine word %0d", dco_ctl_fine_mon));
	a_dac: assert property (@(negedge clk_refp) !chk_dac || sel_b_prev == one_cold(dac_ctl_mon))
		else log_error($sformatf("dac_sel_b %h, zero expected at %0d", sel_b_prev, dac_ctl_mon));
	a_ofs: assert property (@(negedge clk_refp) !chk_ofs ||
		$countones(dco_ctl.offset_thm) == exp_ofs)
		else log_error($sformatf("offset_thm %b, expected %0d ones", dco_ctl.offset_thm, exp_ofs));
	a_inj: assert property (@(negedge clk_refp) !chk_inj || inj_mode_sync == exp_inj)
		else log_error($sformatf("inj_mode_sync %b, expected %b", inj_mode_sync, exp_inj));
	a_fcal: assert property (@(negedge clk_refp) !chk_fcal ||
		(fcal_ready && int'(fcal_cnt) >= exp_lo && int'(fcal_cnt) <= exp_hi))
		else log_error($sformatf("fcal_cnt %0d ready %b, expected %0d..%0d",
			fcal_cnt, fcal_ready, exp_lo, exp_hi));

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin
		int k;
		int g;
		int ld;
		int win;
		logic [31:0] rnd;
		seed = 10;
		err_cnt = 0;
		err_start = 0;
		test_cnt = 0;
		fail_cnt = 0;
		{chk_reset, chk_range, chk_const, chk_dec, chk_dac, chk_ofs, chk_inj, chk_fcal} = '0;
		exp_lo = 0;
		exp_hi = 0;
		exp_msb = 0;
		exp_ofs = 0;
		exp_inj = 1'b0;
		exp_dac = '0;
		fine_ref = '0;
		rst_n = 1'b0;
		bb_out_inc = 1'b0;
		inj_mode = 1'b0;
		en_osc = 1'b0;
		en_monitor = 1'b0;
		load_offset = 1'b0;
		dco_ctl_offset = '0;
		lf_cfg = '0;
		fcal_cfg = '0;
		repeat (16) @(posedge clk_refp);
		#1;
		rst_n = 1'b1;

		// reset values with the loop idle
		start_test();
		exp_msb = (1 << (mdll_pkg::N_DCO_TI - 1)) >> mdll_pkg::N_PI;
		exp_dac = '0;
		exp_dac[mdll_pkg::N_DAC_TI-1] = 1'b1;	// mid-scale
		chk_reset = 1'b1;
		tick(1);
		chk_reset = 1'b0;
		finish_test("reset state");

		// tracking up from a loaded value
		start_test();
		en_osc = 1'b1;
		en_monitor = 1'b1;
		bb_out_inc = 1'b1;
		lf_cfg.freeze_dco = 1'b1;
		lf_cfg.freeze_dac = 1'b1;
		g = 2;
		ld = 40;
		lf_cfg.gain_bb = g[mdll_pkg::N_BB_GB-1:0];
		lf_cfg.dco_ld_value = ld[mdll_pkg::N_DCO_TI-1:0];
		lf_cfg.load = 1'b1;
		tick(1);
		lf_cfg.load = 1'b0;
		tick(DEPTH + 1);	// decision through the synchronizer
		k = 64;
		lf_cfg.freeze_dco = 1'b0;
		tick(k);
		lf_cfg.freeze_dco = 1'b1;
		tick(2);
		exp_lo = ld + (k << g) / (1 << mdll_pkg::N_DCO_TF) - 1;
		exp_hi = exp_lo + 2;
		chk_range = 1'b1;
		tick(1);
		chk_range = 1'b0;
		lf_cfg.gain_bb = 3'd7;	// 8 lsb per step reaches the top fast
		lf_cfg.freeze_dco = 1'b0;
		tick(60);
		lf_cfg.freeze_dco = 1'b1;
		tick(2);
		exp_lo = (1 << mdll_pkg::N_DCO_TI) - 1;
		exp_hi = exp_lo;
		chk_range = 1'b1;
		tick(1);
		chk_range = 1'b0;
		fine_ref = exp_hi[mdll_pkg::N_DCO_TI-1:0];	// full scale
		chk_const = 1'b1;
		for (int i = 0; i < 30; i++) begin
			rnd = $random(seed);
			bb_out_inc = rnd[0];
			tick(1);
		end
		chk_const = 1'b0;
		finish_test("tracking");

		// decoder split with the loop frozen
		start_test();
		for (int i = 0; i < 8; i++) begin
			rnd = $random(seed);
			lf_cfg.dco_ld_value = rnd[mdll_pkg::N_DCO_TI-1:0];
			fine_ref = rnd[mdll_pkg::N_DCO_TI-1:0];	// monitor must show the load
			lf_cfg.load = 1'b1;
			tick(1);
			lf_cfg.load = 1'b0;
			tick(1);
			chk_dec = 1'b1;
			chk_const = 1'b1;
			tick(1);
			chk_dec = 1'b0;
			chk_const = 1'b0;
		end
		finish_test("decoding");

		// dac loop with the dco parked
		start_test();
		lf_cfg.gain_bb_dac = 3'd4;	// one dac lsb per step
		lf_cfg.sel_dac_loop = 1'b1;
		lf_cfg.en_hold = 1'b1;
		lf_cfg.freeze_dco = 1'b0;
		lf_cfg.freeze_dac = 1'b0;
		tick(2);
		chk_const = 1'b1;	// fine_ref still holds the last load
		chk_dac = 1'b1;
		for (int i = 0; i < 200; i++) begin
			rnd = $random(seed);
			bb_out_inc = rnd[0];
			tick(1);
		end
		chk_const = 1'b0;
		chk_dac = 1'b0;
		lf_cfg.freeze_dac = 1'b1;
		lf_cfg.freeze_dco = 1'b1;
		lf_cfg.sel_dac_loop = 1'b0;
		lf_cfg.en_hold = 1'b0;
		finish_test("dac loop");

		// coarse offset register
		start_test();
		for (int v = 0; v < 2 ** mdll_pkg::N_DCO_O; v++) begin
			load_offset = 1'b1;
			dco_ctl_offset = v[mdll_pkg::N_DCO_O-1:0];
			tick(1);
			exp_ofs = v;
			chk_ofs = 1'b1;
			tick(1);
			chk_ofs = 1'b0;
		end
		load_offset = 1'b0;	// offset input left nonzero
		tick(1);
		exp_ofs = 0;
		chk_ofs = 1'b1;
		tick(1);
		chk_ofs = 1'b0;
		finish_test("offset");

		// injection mode through the synchronizer
		start_test();
		for (int i = 0; i < 4; i++) begin
			exp_inj = inj_mode;	// old level for DEPTH edges
			inj_mode = ~inj_mode;
			chk_inj = 1'b1;
			tick(DEPTH);
			exp_inj = inj_mode;
			tick(2);
			chk_inj = 1'b0;
		end
		finish_test("injection mode");

		// frequency calibration over two window lengths
		start_test();
		for (int r = 0; r < 2; r++) begin
			win = (r == 0) ? 10 : 8;
			fcal_cfg.en_fcal = 1'b1;
			fcal_cfg.ndiv_ref = win[mdll_pkg::N_FCAL_DIV-1:0];
			fcal_cfg.start = 1'b1;
			wait_ready(1'b1, 2 * (1 << win) + 16, "fcal_ready did not rise after start");
			exp_lo = (1 << win) / FB_DIV - 1;
			exp_hi = exp_lo + 2;
			chk_fcal = 1'b1;
			tick(1);
			chk_fcal = 1'b0;
			fcal_cfg.start = 1'b0;
			wait_ready(1'b0, 16, "fcal_ready did not fall after start dropped");
		end
		finish_test("calibration");

		$display("tests run %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/mdll_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mdll_core #(
	parameter int DEPTH = 2	// sync depth for async inputs
) (
	input wire logic clk_refp,	// reference clock
	input wire logic rst_n,
	input wire logic bb_out_inc,	// bb pd output, async
	input wire logic inj_mode,	// 0 ring osc, 1 injection, async
	input wire logic clk_fb,	// from the feedback divider
	input wire logic en_osc,
	input wire logic en_monitor,
	input wire logic load_offset,
	input wire logic [mdll_pkg::N_DCO_O-1:0] dco_ctl_offset,
	input wire mdll_pkg::lf_cfg_t lf_cfg,
	input wire mdll_pkg::fcal_cfg_t fcal_cfg,
	output mdll_pkg::dco_ctl_t dco_ctl,	// to the ring oscillator
	output logic inj_mode_sync,
	output logic [mdll_pkg::N_FCAL_CNT-1:0] fcal_cnt,
	output logic fcal_ready,
	output logic [mdll_pkg::N_DCO_TI-1:0] dco_ctl_fine_mon,
	output logic [mdll_pkg::N_DAC_TI-1:0] dac_ctl_mon
);

	// ------------------------------
	// internal nets
	// ------------------------------
	logic bb_inc_s;	// synced decision
	logic fb_edge;	// feedback rise pulse
	logic [mdll_pkg::N_DCO_TI-1:0] dco_ctl_fine;
	logic [mdll_pkg::N_DAC_TI-1:0] dac_ctl;

	// sync, edge detect, monitors
	mdll_ctrl #(
		.DEPTH(DEPTH)
	) u_ctrl (
		.clk_refp(clk_refp),
		.rst_n(rst_n),
		.bb_out_inc(bb_out_inc),
		.inj_mode(inj_mode),
		.clk_fb(clk_fb),
		.en_monitor(en_monitor),
		.dco_ctl_fine(dco_ctl_fine),
		.dac_ctl(dac_ctl),
		.bb_inc_s(bb_inc_s),
		.inj_mode_sync(inj_mode_sync),
		.fb_edge(fb_edge),
		.dco_ctl_fine_mon(dco_ctl_fine_mon),
		.dac_ctl_mon(dac_ctl_mon)
	);

	// bang-bang loop filter
	mdll_lf u_lf (
		.clk_refp(clk_refp),
		.rst_n(rst_n),
		.en_osc(en_osc),
		.bb_inc_s(bb_inc_s),
		.cfg(lf_cfg),
		.dco_ctl_fine(dco_ctl_fine),
		.dac_ctl(dac_ctl)
	);

	mdll_fcal_counter u_fcal (
		.clk_refp(clk_refp),
		.rst_n(rst_n),
		.fb_edge(fb_edge),
		.cfg(fcal_cfg),
		.fcal_cnt(fcal_cnt),
		.fcal_ready(fcal_ready)
	);

	// binary words to osc select lines
	mdll_dco_decoder u_dec (
		.clk_refp(clk_refp),
		.rst_n(rst_n),
		.load_offset(load_offset),
		.dco_ctl_offset(dco_ctl_offset),
		.dco_ctl_fine(dco_ctl_fine),
		.dac_ctl(dac_ctl),
		.dco_ctl(dco_ctl)
	);

endmodule

`default_nettype wire

/* verilog/mdll_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mdll_ctrl #(
	parameter int DEPTH = 2	// synchronizer stages
) (
	input wire logic clk_refp,
	input wire logic rst_n,
	input wire logic bb_out_inc,	// raw bb pd decision, async
	input wire logic inj_mode,	// async mode bit
	input wire logic clk_fb,	// divided feedback clock, async
	input wire logic en_monitor,
	input wire logic [mdll_pkg::N_DCO_TI-1:0] dco_ctl_fine,
	input wire logic [mdll_pkg::N_DAC_TI-1:0] dac_ctl,
	output logic bb_inc_s,
	output logic inj_mode_sync,
	output logic fb_edge,	// one pulse per clk_fb rise
	output logic [mdll_pkg::N_DCO_TI-1:0] dco_ctl_fine_mon,
	output logic [mdll_pkg::N_DAC_TI-1:0] dac_ctl_mon
);

	// bit positions inside the sync chain
	localparam int I_BB  = 0;
	localparam int I_INJ = 1;
	localparam int I_FB  = 2;

	logic [2:0] async_in;	// all async inputs side by side
	logic [DEPTH-1:0][2:0] sync_q;	// stage 0 sees the raw inputs
	logic fb_s;	// synchronized feedback clock
	logic fb_q;	// previous fb_s

	// ------------------------------
	// synchronizers
	// ------------------------------
	assign async_in = {clk_fb, inj_mode, bb_out_inc};

	always_ff @(posedge clk_refp or negedge rst_n) begin
		if (!rst_n) begin
			sync_q <= '0;
		end else begin
			sync_q[0] <= async_in;
			for (int i = 1; i < DEPTH; i++) begin
				sync_q[i] <= sync_q[i-1];	// shift toward the output
			end
		end
	end

	assign bb_inc_s      = sync_q[DEPTH-1][I_BB];
	assign inj_mode_sync = sync_q[DEPTH-1][I_INJ];
	assign fb_s          = sync_q[DEPTH-1][I_FB];

	// ------------------------------
	// feedback edge detect
	// ------------------------------
	always_ff @(posedge clk_refp or negedge rst_n) begin
		if (!rst_n) begin
			fb_q <= 1'b0;
		end else begin
			fb_q <= fb_s;
		end
	end

	// clk_fb slower than clk_refp/2, so pulses never merge
	assign fb_edge = fb_s & ~fb_q;

	// ------------------------------
	// monitor sampling
	// ------------------------------
	always_ff @(posedge clk_refp or negedge rst_n) begin
		if (!rst_n) begin
			dco_ctl_fine_mon <= '0;
			dac_ctl_mon      <= '0;
		end else if (en_monitor) begin	// hold last sample otherwise
			dco_ctl_fine_mon <= dco_ctl_fine;
			dac_ctl_mon      <= dac_ctl;
		end
	end

endmodule

`default_nettype wire

/* verilog/mdll_dco_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mdll_dco_decoder (
	input wire logic clk_refp,
	input wire logic rst_n,
	input wire logic load_offset,	// 0 forces zero offset
	input wire logic [mdll_pkg::N_DCO_O-1:0] dco_ctl_offset,
	input wire logic [mdll_pkg::N_DCO_TI-1:0] dco_ctl_fine,
	input wire logic [mdll_pkg::N_DAC_TI-1:0] dac_ctl,
	output mdll_pkg::dco_ctl_t dco_ctl
);

	localparam int N_OFS = mdll_pkg::N_DCO_O;
	localparam int N_MSB = mdll_pkg::N_FINE_MSB;
	localparam int N_LSB = mdll_pkg::N_PI;
	localparam int N_DAC = mdll_pkg::N_DAC_TI;

	logic [N_OFS-1:0] offset_q;	// registered coarse offset
	logic [N_MSB-1:0] fine_msb;
	logic [N_LSB-1:0] fine_lsb;
	logic [2**N_OFS-2:0] offset_thm;
	logic [2**N_MSB-2:0] msb_thm;
	logic [2**N_LSB-2:0] lsb_thm;
	logic [2**N_DAC-1:0] sel_b;

	// ------------------------------
	// coarse offset
	// ------------------------------
	always_ff @(posedge clk_refp or negedge rst_n) begin
		if (!rst_n) begin
			offset_q <= '0;
		end else begin
			offset_q <= load_offset ? dco_ctl_offset : '0;
		end
	end

	// fine word split, msb and lsb decoded separately
	assign fine_msb = dco_ctl_fine[mdll_pkg::N_DCO_TI-1 -: N_MSB];
	assign fine_lsb = dco_ctl_fine[N_LSB-1:0];

	// ------------------------------
	// decoders
	// ------------------------------
	// thermometer, bit i set while value > i
	for (genvar i = 0; i < 2**N_OFS-1; i++) begin : g_ofs
		assign offset_thm[i] = (offset_q > N_OFS'(i));
	end
	for (genvar i = 0; i < 2**N_MSB-1; i++) begin : g_msb
		assign msb_thm[i] = (fine_msb > N_MSB'(i));
	end
	for (genvar i = 0; i < 2**N_LSB-1; i++) begin : g_lsb
		assign lsb_thm[i] = (fine_lsb > N_LSB'(i));
	end
	// one-cold dac select
	for (genvar i = 0; i < 2**N_DAC; i++) begin : g_dac
		assign sel_b[i] = (dac_ctl != N_DAC'(i));
	end

	always_comb begin
		dco_ctl.offset_thm   = offset_thm;
		dco_ctl.fine_msb_thm = msb_thm;
		dco_ctl.fine_lsb_thm = lsb_thm;
		dco_ctl.dac_sel_b    = sel_b;
	end

endmodule

`default_nettype wire

/* verilog/mdll_fcal_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module mdll_fcal_counter (
	input wire logic clk_refp,
	input wire logic rst_n,
	input wire logic fb_edge,	// one pulse per feedback rise
	input wire mdll_pkg::fcal_cfg_t cfg,
	output logic [mdll_pkg::N_FCAL_CNT-1:0] fcal_cnt,
	output logic fcal_ready	// acknowledge
);

	localparam int W_WIN = 2 ** mdll_pkg::N_FCAL_DIV;	// fits 2**15 cycles

	// fsm states
	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_COUNT = 2'd1;
	localparam logic [1:0] ST_DONE  = 2'd2;

	logic [1:0] state;
	logic start_q;	// start, one cycle back
	logic start_rise;
	logic [W_WIN-1:0] win_cnt;	// ref cycles into the window
	logic [W_WIN-1:0] win_last;
	logic [mdll_pkg::N_FCAL_CNT-1:0] cnt;
	logic cnt_full;

	assign start_rise = cfg.start & ~start_q;
	assign win_last   = (W_WIN'(1) << cfg.ndiv_ref) - W_WIN'(1);
	assign cnt_full   = &cnt;

	always_ff @(posedge clk_refp or negedge rst_n) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			start_q <= 1'b0;
			win_cnt <= '0;
			cnt     <= '0;
		end else begin
			start_q <= cfg.start;
			case (state)
				ST_IDLE: begin
					if (cfg.en_fcal && start_rise) begin	// new request
						state   <= ST_COUNT;
						win_cnt <= '0;
						cnt     <= '0;
					end
				end
				ST_COUNT: begin
					if (!cfg.en_fcal || !cfg.start) begin
						state <= ST_IDLE;	// request withdrawn, abort
					end else begin
						if (fb_edge && !cnt_full) begin
							cnt <= cnt + 1'b1;	// saturating
						end
						if (win_cnt == win_last) begin
							state <= ST_DONE;
						end else begin
							win_cnt <= win_cnt + 1'b1;
						end
					end
				end
				ST_DONE: begin
					if (!cfg.start) begin
						state <= ST_IDLE;	// ready drops with start
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign fcal_cnt   = cnt;	// held through done
	assign fcal_ready = (state == ST_DONE);

endmodule

`default_nettype wire

/* verilog/mdll_lf.sv */
`timescale 1ns/1ps
`default_nettype none

module mdll_lf (
	input wire logic clk_refp,
	input wire logic rst_n,
	input wire logic en_osc,	// tracking only while osc runs
	input wire logic bb_inc_s,	// 1 = early, step up
	input wire mdll_pkg::lf_cfg_t cfg,
	output logic [mdll_pkg::N_DCO_TI-1:0] dco_ctl_fine,
	output logic [mdll_pkg::N_DAC_TI-1:0] dac_ctl
);

	// accumulator widths, integer over fraction
	localparam int W_DCO = mdll_pkg::N_DCO_TI + mdll_pkg::N_DCO_TF;
	localparam int W_DAC = mdll_pkg::N_DAC_TI + mdll_pkg::N_DAC_TF;
	// one spare bit so the up step never wraps
	localparam int W_EXT = ((W_DCO > W_DAC) ? W_DCO : W_DAC) + 1;

	localparam logic [W_EXT-1:0] DCO_FULL = (W_EXT'(1) << W_DCO) - W_EXT'(1);
	localparam logic [W_EXT-1:0] DAC_FULL = (W_EXT'(1) << W_DAC) - W_EXT'(1);
	localparam logic [W_DCO-1:0] DCO_MID  = W_DCO'(1) << (W_DCO - 1);	// int 2**(n-1), frac 0
	localparam logic [W_DAC-1:0] DAC_MID  = W_DAC'(1) << (W_DAC - 1);

	logic [W_DCO-1:0] dco_acc;	// dco track acc
	logic [W_DAC-1:0] dac_acc;	// dac track acc
	logic [W_EXT-1:0] dco_step;
	logic [W_EXT-1:0] dac_step;
	logic [W_EXT-1:0] dco_sum;	// next dco value, saturated
	logic [W_EXT-1:0] dac_sum;
	logic dco_move;
	logic dac_move;

	// one saturating bang-bang step
	function automatic logic [W_EXT-1:0] sat_step(
		input logic [W_EXT-1:0] acc,
		input logic [W_EXT-1:0] step,
		input logic [W_EXT-1:0] full,
		input logic up
	);
		logic [W_EXT-1:0] res;
		if (up) begin
			res = acc + step;
			if (res > full) begin
				res = full;	// clip at top
			end
		end else begin
			res = (acc < step) ? '0 : acc - step;	// clip at zero
		end
		return res;
	endfunction

	// ------------------------------
	// step and enables
	// ------------------------------
	assign dco_step = W_EXT'(1) << cfg.gain_bb;
	assign dac_step = W_EXT'(1) << cfg.gain_bb_dac;

	// dac mode with hold parks the dco path
	assign dco_move = en_osc & ~cfg.freeze_dco & ~(cfg.sel_dac_loop & cfg.en_hold);
	assign dac_move = en_osc & cfg.sel_dac_loop & ~cfg.freeze_dac;

	always_comb begin
		dco_sum = sat_step(W_EXT'(dco_acc), dco_step, DCO_FULL, bb_inc_s);
		dac_sum = sat_step(W_EXT'(dac_acc), dac_step, DAC_FULL, bb_inc_s);
	end

	// ------------------------------
	// accumulators
	// ------------------------------
	always_ff @(posedge clk_refp or negedge rst_n) begin
		if (!rst_n) begin
			dco_acc <= DCO_MID;
			dac_acc <= DAC_MID;
		end else if (cfg.load) begin	// load beats tracking
			dco_acc <= {cfg.dco_ld_value, {mdll_pkg::N_DCO_TF{1'b0}}};
			dac_acc <= {cfg.dac_ld_value, {mdll_pkg::N_DAC_TF{1'b0}}};
		end else begin
			if (dco_move) begin
				dco_acc <= dco_sum[W_DCO-1:0];
			end
			if (dac_move) begin
				dac_acc <= dac_sum[W_DAC-1:0];
			end
		end
	end

	// integer parts drive the oscillator
	assign dco_ctl_fine = dco_acc[W_DCO-1 -: mdll_pkg::N_DCO_TI];
	assign dac_ctl      = dac_acc[W_DAC-1 -: mdll_pkg::N_DAC_TI];

endmodule

`default_nettype wire

/* verilog/mdll_pkg.sv */
`default_nettype none

package mdll_pkg;

	// ------------------------------
	// word widths
	// ------------------------------
	localparam int N_DCO_TI   = 8;	// dco fine control, integer bits
	localparam int N_DCO_TF   = 4;	// dco track fraction bits
	localparam int N_PI       = 3;	// lsb part of the fine word
	localparam int N_DCO_O    = 2;	// coarse offset
	localparam int N_DAC_TI   = 4;	// dac control, integer bits
	localparam int N_DAC_TF   = 4;	// dac track fraction bits
	localparam int N_BB_GB    = 3;	// dco gain exponent
	localparam int N_BB_GDAC  = 3;	// dac gain exponent
	localparam int N_FCAL_CNT = 10;	// calibration count
	localparam int N_FCAL_DIV = 4;	// ref window exponent

	localparam int N_FINE_MSB = N_DCO_TI - N_PI;	// upper part of fine word

	// loop filter configuration, static while tracking
	typedef struct packed {
		logic freeze_dco;	// hold dco track acc
		logic freeze_dac;	// hold dac track acc
		logic load;	// load init values, wins over tracking
		logic sel_dac_loop;	// dac-based bb loop
		logic en_hold;	// dco acc parked in dac mode
		logic [N_BB_GB-1:0] gain_bb;	// step = 2**gain_bb lsb
		logic [N_BB_GDAC-1:0] gain_bb_dac;
		logic [N_DCO_TI-1:0] dco_ld_value;	// integer part only
		logic [N_DAC_TI-1:0] dac_ld_value;
	} lf_cfg_t;

	// calibration request
	typedef struct packed {
		logic en_fcal;
		logic start;	// request, level held until ready
		logic [N_FCAL_DIV-1:0] ndiv_ref;	// window = 2**ndiv_ref ref cycles
	} fcal_cfg_t;

	// oscillator select lines
	typedef struct packed {
		logic [2**N_DCO_O-2:0] offset_thm;	// coarse stages, thermometer
		logic [2**N_FINE_MSB-2:0] fine_msb_thm;
		logic [2**N_PI-2:0] fine_lsb_thm;
		logic [2**N_DAC_TI-1:0] dac_sel_b;	// one-cold
	} dco_ctl_t;

endpackage

`default_nettype wire
